//--- sim.f
src/dataOutPkg.sv
src/dataOutController.sv
src/dqSerializer.sv
src/nandPinDriver.sv
src/padStage.sv
src/dataOutSync.sv
test/dataOutSync_chk.sv
test/dataOutSyncTb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the dataOutSync testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module dataOutSyncTb -f sim.f -o dataOutSyncSim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/dataOutSyncSim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "ALL CHECKS PASSED"; then
    exit 0
fi
exit 1

//--- test/dataOutSyncTb.sv
`timescale 1ns/100ps

module dataOutSyncTb;

    localparam int NumberOfWays    = 4;
    localparam int PreambleCycles  = 4;
    localparam int PostambleCycles = 2;
    localparam int ClockPeriod     = 100;
    localparam int ResetCycles     = 8;
    localparam int MaxWords        = 16;  // 32 bytes
    localparam int MaxGap          = 3;
    localparam int BurstsPerTest   = 8;
    // request, preamble, gapped words, postamble and idle tail of the longest burst
    localparam int BurstCycles     = 5 + PreambleCycles + PostambleCycles +
                                     MaxWords * (MaxGap + 1);
    localparam int WatchdogCycles  = 2 * (ResetCycles + 4 * BurstsPerTest * BurstCycles);

    localparam logic [7:0] BeatStrobe     = 8'h33;
    localparam logic [3:0] ReadEnPattern  = 4'b0011;
    localparam logic [3:0] WriteEnPattern = 4'b0001;
    localparam logic [3:0] LatchPattern   = 4'b0011;

    // what the pads must show, two edges after the cycle it was predicted for
    typedef struct packed {
        logic                    beat;
        logic                    busy;
        logic [NumberOfWays-1:0] way;
    } padExpect_t;

    logic iSystemClock, iReset, start, writeValid;
    logic ready, lastStep, writeReady, dqsOutEnable, dqOutEnable;
    logic [NumberOfWays-1:0]   targetWay;
    logic [15:0]               numOfData;
    logic [15:0]               writeData;
    logic [7:0]                dqStrobe;
    logic [31:0]               dq;
    logic [2*NumberOfWays-1:0] chipEnable;
    logic [3:0] readEnable, writeEnable, addressLatchEnable, commandLatchEnable;

    padExpect_t              pipe [3];
    logic [15:0]             wordQueue [$];  // accepted words not yet on the pads
    logic [31:0]             expDq;
    logic [NumberOfWays-1:0] curWay;
    int seed = 32'h5317;
    int errorCount = 0;
    int checkCount = 0;
    int testsRun = 0;
    int testsFailed = 0;
    int wordsAccepted = 0;
    int ticksSinceReset = 0;

    dataOutSync #(
        .NumberOfWays    (NumberOfWays),
        .PreambleCycles  (PreambleCycles),
        .PostambleCycles (PostambleCycles)
    ) DUT (.*);

    initial begin
        iSystemClock = 1'b0;
        forever #(ClockPeriod / 2) iSystemClock = ~iSystemClock;
    end

    initial begin
        #(WatchdogCycles * ClockPeriod);
        $display("timeout: run still going after %0d clock cycles", WatchdogCycles);
        $display("CHECKS FAILED");
        $finish;
    end

    function automatic int randomBelow(input int limit);
        int r;
        r = $random(seed);
        return (r & 32'h7fffffff) % limit;
    endfunction

    task automatic compareValue(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        checkCount++;
        if (actual != expected) begin
            $display("mismatch at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
            errorCount++;
        end
    endtask

    task automatic reportFailure(input string what);
        $display("error at %0t: %s", $time, what);
        errorCount++;
    endtask

    task automatic expectControl(input logic readyExp, input logic writeReadyExp,
                                 input logic lastStepExp);
        compareValue("ready", 32'(readyExp), 32'(ready));
        compareValue("writeReady", 32'(writeReadyExp), 32'(writeReady));
        compareValue("lastStep", 32'(lastStepExp), 32'(lastStep));
    endtask

    task automatic checkPads();
        padExpect_t  e;
        logic [15:0] word;
        logic [7:0]  expStrobe;
        logic [3:0]  expLatch;
        e = pipe[2];
        expStrobe = 8'h00;
        expLatch = 4'h0;
        if (e.beat) begin
            word = wordQueue.pop_front();
            expDq = {word[15:8], word[15:8], word[7:0], word[7:0]};  // high byte in upper slots
            expStrobe = BeatStrobe;
            expLatch = LatchPattern;
        end
        compareValue("dqStrobe", 32'(expStrobe), 32'(dqStrobe));
        compareValue("dq", expDq, dq);  // held through gaps
        compareValue("addressLatchEnable", 32'(expLatch), 32'(addressLatchEnable));
        compareValue("commandLatchEnable", 32'(expLatch), 32'(commandLatchEnable));
        compareValue("dqOutEnable", 32'(e.busy), 32'(dqOutEnable));
        compareValue("dqsOutEnable", 32'(e.busy), 32'(dqsOutEnable));
        compareValue("chipEnable", e.busy ? 32'({e.way, e.way}) : 32'd0, 32'(chipEnable));
        compareValue("readEnable", 32'(ReadEnPattern), 32'(readEnable));
        compareValue("writeEnable", (ticksSinceReset >= 2) ? 32'(WriteEnPattern) : 32'd0,
                     32'(writeEnable));
    endtask

    // inputs are already driven; predict the coming edge, then check at the next falling edge
    task automatic tick(input logic busyNext);
        padExpect_t next;
        next.beat = writeValid && writeReady;
        next.busy = busyNext;
        next.way  = curWay;
        if (next.beat) begin
            wordQueue.push_back(writeData);
            wordsAccepted++;
        end
        pipe[2] = pipe[1];
        pipe[1] = pipe[0];
        pipe[0] = next;
        @(negedge iSystemClock);
        ticksSinceReset++;
        checkPads();
    endtask

    task automatic runBurst(input logic [NumberOfWays-1:0] way, input int lenBytes,
                            input int maxGap, input logic startNoise);
        int   gap;
        logic aborted;
        compareValue("ready", 32'd1, 32'(ready));
        curWay = way;
        wordsAccepted = 0;
        aborted = 1'b0;
        start = 1'b1;
        targetWay = way;
        numOfData = 16'(lenBytes);
        tick(1'b0);  // request taken, latch cycle
        expectControl(1'b0, 1'b0, 1'b0);
        // scrambled request fields must not reach the burst
        targetWay = NumberOfWays'(randomBelow(1 << NumberOfWays));
        numOfData = 16'(randomBelow(65536));
        for (int i = 1; i <= PreambleCycles + 1; i++) begin
            start = startNoise && (randomBelow(2) == 1);
            tick(1'b1);
            expectControl(1'b0, i == PreambleCycles + 1, 1'b0);
        end
        while (2 * wordsAccepted < lenBytes && !aborted) begin
            if (!writeReady) begin
                reportFailure($sformatf("writeReady low after %0d of %0d bytes",
                                        2 * wordsAccepted, lenBytes));
                aborted = 1'b1;
            end else begin
                gap = (maxGap > 0) ? randomBelow(maxGap + 1) : 0;
                writeValid = 1'b0;
                repeat (gap) begin
                    writeData = 16'(randomBelow(65536));
                    start = startNoise && (randomBelow(2) == 1);
                    tick(1'b1);
                    expectControl(1'b0, 1'b1, 1'b0);
                end
                writeValid = 1'b1;
                writeData = 16'(randomBelow(65536));
                tick(1'b1);
                expectControl(1'b0, 2 * wordsAccepted < lenBytes, 1'b0);
            end
        end
        if (aborted) begin
            writeValid = 1'b0;
            start = 1'b0;
        end else begin
            writeValid = 1'b1;  // words offered in the postamble must be refused
            for (int k = 1; k <= PostambleCycles; k++) begin
                writeData = 16'(randomBelow(65536));
                start = startNoise && (randomBelow(2) == 1);
                tick(k < PostambleCycles);
                expectControl(1'b0, 1'b0, k == PostambleCycles);
            end
            writeValid = 1'b0;
            tick(1'b0);
            expectControl(1'b1, 1'b0, 1'b0);
            start = 1'b0;
            compareValue("words accepted", lenBytes / 2, wordsAccepted);
        end
    endtask

    task automatic idleCycles(input int count);
        start = 1'b0;
        writeValid = 1'b0;
        repeat (count) begin
            tick(1'b0);
            expectControl(1'b1, 1'b0, 1'b0);  // a stray start would drop ready here
        end
    endtask

    task automatic finishTest(input string name, input int errorsBefore);
        testsRun++;
        if (errorCount == errorsBefore) begin
            $display("test %s passed", name);
        end else begin
            testsFailed++;
            $display("test %s failed with %0d errors", name, errorCount - errorsBefore);
        end
    endtask

    task automatic runBurstTest(input string name, input int maxGap, input logic startNoise,
                                input logic oneHotWays);
        logic [NumberOfWays-1:0] way;
        int                      errorsBefore;
        errorsBefore = errorCount;
        for (int b = 0; b < BurstsPerTest; b++) begin
            way = NumberOfWays'(randomBelow(1 << NumberOfWays));
            if (oneHotWays && b < NumberOfWays)
                way = NumberOfWays'(1 << b);
            runBurst(way, 2 * (randomBelow(MaxWords) + 1), maxGap, startNoise);
            idleCycles(1 + randomBelow(3));
        end
        if (wordQueue.size() != 0)
            reportFailure($sformatf("%0d accepted words never reached dq", wordQueue.size()));
        finishTest(name, errorsBefore);
    endtask

    initial begin
        int errorsBefore;
        iReset = 1'b1;
        start = 1'b0;
        targetWay = '0;
        numOfData = '0;
        writeData = '0;
        writeValid = 1'b0;
        expDq = '0;
        curWay = '0;
        foreach (pipe[i])
            pipe[i] = '0;
        errorsBefore = errorCount;
        repeat (ResetCycles) @(negedge iSystemClock);
        compareValue("ready", 32'd0, 32'(ready));
        compareValue("writeReady", 32'd0, 32'(writeReady));
        compareValue("lastStep", 32'd0, 32'(lastStep));
        compareValue("dqStrobe", 32'd0, 32'(dqStrobe));
        compareValue("dq", 32'd0, dq);
        compareValue("chipEnable", 32'd0, 32'(chipEnable));
        compareValue("addressLatchEnable", 32'd0, 32'(addressLatchEnable));
        compareValue("commandLatchEnable", 32'd0, 32'(commandLatchEnable));
        compareValue("dqsOutEnable", 32'd0, 32'(dqsOutEnable));
        compareValue("dqOutEnable", 32'd0, 32'(dqOutEnable));
        iReset = 1'b0;
        tick(1'b0);
        expectControl(1'b1, 1'b0, 1'b0);  // ready one edge after release
        finishTest("reset", errorsBefore);
        runBurstTest("data path", 0, 1'b0, 1'b0);
        runBurstTest("back-pressure", MaxGap, 1'b0, 1'b0);
        runBurstTest("way select", 1, 1'b0, 1'b1);
        runBurstTest("completion", 2, 1'b1, 1'b0);
        $display("tests run %0d, failed %0d, checks %0d, errors %0d",
                 testsRun, testsFailed, checkCount, errorCount);
        if (errorCount == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

//--- test/dataOutSync_chk.sv
`timescale 1ns/100ps

module dataOutSyncChk
    import dataOutPkg::*;
(
    input logic                   iSystemClock,
    input logic                   iReset,
    input logic                   ready,
    input logic                   writeReady,
    input logic                   lastStep,
    input logic                   dqsOutEnable,
    input logic [StrobeWidth-1:0] dqStrobe
);

    // command and stream handshakes never overlap
    writeReadyOutsideReady: assert property (
        @(posedge iSystemClock) disable iff (iReset)
        !(writeReady && ready)
    ) else $error("writeReady high while ready is high");

    lastStepOneCycle: assert property (
        @(posedge iSystemClock) disable iff (iReset)
        lastStep |=> !lastStep
    ) else $error("lastStep held for more than one cycle");

    strobeOnlyWhenEnabled: assert property (
        @(posedge iSystemClock) disable iff (iReset)
        (dqStrobe != '0) |-> dqsOutEnable  // no strobe on a released pad
    ) else $error("dqStrobe active while dqsOutEnable is low");

endmodule

bind dataOutSync dataOutSyncChk assertions (.*);

//--- src/dataOutSync.sv
`timescale 1ns/100ps

module dataOutSync
    import dataOutPkg::*;
#(
    parameter int NumberOfWays    = 4,
    parameter int PreambleCycles  = 4,  // tDQSS
    parameter int PostambleCycles = 2
) (
    input  logic                      iSystemClock,
    input  logic                      iReset,

    // command handshake
    input  logic                      start,
    input  logic [NumberOfWays-1:0]   targetWay,
    input  logic [CountWidth-1:0]     numOfData,
    output logic                      ready,
    output logic                      lastStep,

    // write stream
    input  logic [WordWidth-1:0]      writeData,
    input  logic                      writeValid,
    output logic                      writeReady,

    // pads
    output logic                      dqsOutEnable,
    output logic                      dqOutEnable,
    output logic [StrobeWidth-1:0]    dqStrobe,
    output logic [DqWidth-1:0]        dq,
    output logic [2*NumberOfWays-1:0] chipEnable,
    output logic [PinWidth-1:0]       readEnable,
    output logic [PinWidth-1:0]       writeEnable,
    output logic [PinWidth-1:0]       addressLatchEnable,
    output logic [PinWidth-1:0]       commandLatchEnable
);

    phase_t                    phase;
    logic [NumberOfWays-1:0]   wayLatched;
    dqLane_t                   dqLane;
    pinLane_t                  pinLane;
    logic [2*NumberOfWays-1:0] chipEnableLane;

    dataOutController #(
        .NumberOfWays    (NumberOfWays),
        .PreambleCycles  (PreambleCycles),
        .PostambleCycles (PostambleCycles)
    ) controller (
        .iSystemClock (iSystemClock),
        .iReset       (iReset),
        .start        (start),
        .targetWay    (targetWay),
        .numOfData    (numOfData),
        .writeData    (writeData),
        .writeValid   (writeValid),
        .ready        (ready),
        .writeReady   (writeReady),
        .lastStep     (lastStep),
        .phase        (phase),
        .wayLatched   (wayLatched)
    );

    dqSerializer serializer (
        .iSystemClock (iSystemClock),
        .iReset       (iReset),
        .phase        (phase),
        .lane         (dqLane)
    );

    nandPinDriver #(
        .NumberOfWays (NumberOfWays)
    ) pinDriver (
        .iSystemClock (iSystemClock),
        .iReset       (iReset),
        .phase        (phase),
        .wayLatched   (wayLatched),
        .pins         (pinLane),
        .chipEnable   (chipEnableLane)
    );

    padStage #(
        .NumberOfWays (NumberOfWays)
    ) pads (
        .iSystemClock       (iSystemClock),
        .iReset             (iReset),
        .dqIn               (dqLane),
        .pinsIn             (pinLane),
        .chipEnableIn       (chipEnableLane),
        .busy               (phase.busy),
        .dqsOutEnable       (dqsOutEnable),
        .dqOutEnable        (dqOutEnable),
        .dqStrobe           (dqStrobe),
        .dq                 (dq),
        .chipEnable         (chipEnable),
        .readEnable         (readEnable),
        .writeEnable        (writeEnable),
        .addressLatchEnable (addressLatchEnable),
        .commandLatchEnable (commandLatchEnable)
    );

endmodule

//--- src/padStage.sv
`timescale 1ns/100ps

module padStage
    import dataOutPkg::*;
#(
    parameter int NumberOfWays = 4
) (
    input  logic                      iSystemClock,
    input  logic                      iReset,
    input  dqLane_t                   dqIn,
    input  pinLane_t                  pinsIn,
    input  logic [2*NumberOfWays-1:0] chipEnableIn,
    input  logic                      busy,
    output logic                      dqsOutEnable,
    output logic                      dqOutEnable,
    output logic [StrobeWidth-1:0]    dqStrobe,
    output logic [DqWidth-1:0]        dq,
    output logic [2*NumberOfWays-1:0] chipEnable,
    output logic [PinWidth-1:0]       readEnable,
    output logic [PinWidth-1:0]       writeEnable,
    output logic [PinWidth-1:0]       addressLatchEnable,
    output logic [PinWidth-1:0]       commandLatchEnable
);

    dqLane_t                   dqReg;
    pinLane_t                  pinsReg;
    logic [2*NumberOfWays-1:0] chipEnableReg;
    logic                      busyDelay;  // matches the lane register stage
    logic                      outEnable;

    always_ff @(posedge iSystemClock or posedge iReset) begin
        if (iReset) begin
            dqReg         <= '0;
            pinsReg       <= '{
                readEnable:         ReadEnIdle,
                writeEnable:        '0,
                addressLatchEnable: '0,
                commandLatchEnable: '0
            };
            chipEnableReg <= '0;
            busyDelay     <= 1'b0;
            outEnable     <= 1'b0;
        end else begin
            dqReg         <= dqIn;
            pinsReg       <= pinsIn;
            chipEnableReg <= chipEnableIn;
            busyDelay     <= busy;
            outEnable     <= busyDelay;  // lines up with chipEnable
        end
    end

    assign dqsOutEnable       = outEnable;
    assign dqOutEnable        = outEnable;
    assign dqStrobe           = dqReg.strobe;
    assign dq                 = dqReg.dq;
    assign chipEnable         = chipEnableReg;
    assign readEnable         = pinsReg.readEnable;
    assign writeEnable        = pinsReg.writeEnable;
    assign addressLatchEnable = pinsReg.addressLatchEnable;
    assign commandLatchEnable = pinsReg.commandLatchEnable;

endmodule

//--- src/nandPinDriver.sv
`timescale 1ns/100ps

module nandPinDriver
    import dataOutPkg::*;
#(
    parameter int NumberOfWays = 4
) (
    input  logic                      iSystemClock,
    input  logic                      iReset,
    input  phase_t                    phase,
    input  logic [NumberOfWays-1:0]   wayLatched,
    output pinLane_t                  pins,
    output logic [2*NumberOfWays-1:0] chipEnable
);

    logic [PinWidth-1:0] latchPattern;

    // ALE and CLE move together on data beats
    assign latchPattern = phase.beat ? LatchBeat : '0;

    always_ff @(posedge iSystemClock or posedge iReset) begin
        if (iReset) begin
            pins <= '{
                readEnable:         ReadEnIdle,
                writeEnable:        '0,
                addressLatchEnable: '0,
                commandLatchEnable: '0
            };
        end else begin
            pins.readEnable         <= ReadEnIdle;
            pins.writeEnable        <= WriteEnActive;
            pins.addressLatchEnable <= latchPattern;
            pins.commandLatchEnable <= latchPattern;
        end
    end

    // both CE halves select the same way
    always_ff @(posedge iSystemClock or posedge iReset) begin
        if (iReset)
            chipEnable <= '0;
        else if (phase.busy)
            chipEnable <= {wayLatched, wayLatched};
        else
            chipEnable <= '0;
    end

endmodule

//--- src/dqSerializer.sv
`timescale 1ns/100ps

module dqSerializer
    import dataOutPkg::*;
(
    input  logic    iSystemClock,
    input  logic    iReset,
    input  phase_t  phase,
    output dqLane_t lane
);

    localparam int ByteWidth = WordWidth / 2;

    logic [ByteWidth-1:0] highByte;
    logic [ByteWidth-1:0] lowByte;
    logic [DqWidth-1:0]   beatPattern;

    assign highByte = phase.word[WordWidth-1 -: ByteWidth];
    assign lowByte  = phase.word[ByteWidth-1:0];

    // each byte goes out on both edges of its strobe half
    assign beatPattern = {highByte, highByte, lowByte, lowByte};

    always_ff @(posedge iSystemClock or posedge iReset) begin
        if (iReset) begin
            lane <= '0;
        end else if (phase.beat) begin
            lane.dq     <= beatPattern;
            lane.strobe <= StrobeBeat;
        end else begin
            lane.strobe <= '0;  // dq holds
        end
    end

endmodule

//--- src/dataOutController.sv
`timescale 1ns/100ps

module dataOutController
    import dataOutPkg::*;
#(
    parameter int NumberOfWays    = 4,
    parameter int PreambleCycles  = 4,
    parameter int PostambleCycles = 2
) (
    input  logic                    iSystemClock,
    input  logic                    iReset,
    input  logic                    start,
    input  logic [NumberOfWays-1:0] targetWay,
    input  logic [CountWidth-1:0]   numOfData,
    input  logic [WordWidth-1:0]    writeData,
    input  logic                    writeValid,
    output logic                    ready,
    output logic                    writeReady,
    output logic                    lastStep,
    output phase_t                  phase,
    output logic [NumberOfWays-1:0] wayLatched
);

    localparam int MaxWait    = (PreambleCycles > PostambleCycles) ?
                                PreambleCycles : PostambleCycles;
    localparam int TimerWidth = $clog2(MaxWait + 1);

    typedef enum logic [2:0] {
        StateReady,
        StateLatch,
        StatePreamble,  // tDQSS
        StateStream,
        StatePostamble,
        StateLastStep
    } state_t;

    state_t                state;
    logic [TimerWidth-1:0] timer;
    logic [CountWidth-1:0] byteCount;
    logic [CountWidth-1:0] nextCount;
    logic [CountWidth-1:0] countLatched;
    logic [WordWidth-1:0]  wordReg;
    logic                  beatReg;
    logic                  busy;
    logic                  accept;
    logic                  transfer;
    logic                  timerDone;

    assign accept    = start & ready;
    assign transfer  = writeValid & writeReady;
    assign timerDone = (timer == '0);
    assign nextCount = byteCount + CountWidth'(2);  // two bytes per word
    assign busy      = state inside {StatePreamble, StateStream, StatePostamble};

    always_ff @(posedge iSystemClock or posedge iReset) begin
        if (iReset) begin
            state      <= StateReady;
            ready      <= 1'b0;
            writeReady <= 1'b0;
            lastStep   <= 1'b0;
            timer      <= '0;
            byteCount  <= '0;
        end else begin
            case (state)
                StateReady: begin
                    ready     <= ~accept;  // also the first edge out of reset
                    byteCount <= '0;
                    if (accept)
                        state <= StateLatch;
                end
                StateLatch: begin
                    timer <= TimerWidth'(PreambleCycles - 1);
                    state <= StatePreamble;
                end
                StatePreamble: begin
                    timer <= timer - 1'b1;
                    if (timerDone) begin
                        writeReady <= 1'b1;
                        state      <= StateStream;
                    end
                end
                StateStream: begin
                    if (transfer) begin
                        byteCount <= nextCount;
                        // last word of the burst
                        if (nextCount == countLatched) begin
                            writeReady <= 1'b0;
                            timer      <= TimerWidth'(PostambleCycles - 1);
                            state      <= StatePostamble;
                        end
                    end
                end
                StatePostamble: begin
                    timer <= timer - 1'b1;
                    if (timerDone) begin
                        lastStep <= 1'b1;
                        state    <= StateLastStep;
                    end
                end
                StateLastStep: begin
                    lastStep <= 1'b0;
                    ready    <= 1'b1;
                    state    <= StateReady;
                end
                default: state <= StateReady;
            endcase
        end
    end

    always_ff @(posedge iSystemClock or posedge iReset) begin
        if (iReset)
            beatReg <= 1'b0;
        else
            beatReg <= transfer;
    end

    // request and word payload
    always_ff @(posedge iSystemClock) begin
        if (accept) begin
            wayLatched   <= targetWay;
            countLatched <= numOfData;
        end
        if (transfer)
            wordReg <= writeData;
    end

    assign phase = '{busy: busy, beat: beatReg, word: wordReg};

endmodule

//--- src/dataOutPkg.sv
package dataOutPkg;

    // pad bus geometry
    localparam int WordWidth   = 16;
    localparam int DqWidth     = 32;  // four byte slots
    localparam int StrobeWidth = 8;
    localparam int CountWidth  = 16;
    localparam int PinWidth    = 4;

    // what the controller hands to both lanes each cycle
    typedef struct packed {
        logic                 busy;  // preamble through postamble
        logic                 beat;  // word accepted last edge
        logic [WordWidth-1:0] word;
    } phase_t;

    // serializer result
    typedef struct packed {
        logic [DqWidth-1:0]     dq;
        logic [StrobeWidth-1:0] strobe;
    } dqLane_t;

    // pin driver result, one quarter-rate pattern per pin group
    typedef struct packed {
        logic [PinWidth-1:0] readEnable;
        logic [PinWidth-1:0] writeEnable;
        logic [PinWidth-1:0] addressLatchEnable;
        logic [PinWidth-1:0] commandLatchEnable;
    } pinLane_t;

    // DQS toggles on both halves of a beat
    localparam logic [StrobeWidth-1:0] StrobeBeat = 8'h33;

    // RE held in its idle pattern during data out
    localparam logic [PinWidth-1:0] ReadEnIdle = 4'b0011;

    localparam logic [PinWidth-1:0] WriteEnActive = 4'b0001;

    // ALE and CLE both high marks a data beat in DDR mode
    localparam logic [PinWidth-1:0] LatchBeat = 4'b0011;

endpackage
